// ==== filelist.f ====
+incdir+sim
design/wavenet_pkg.sv
design/stage_if.sv
design/input_window.sv
design/dilated_cache.sv
design/conv_layer.sv
design/layer_sequencer.sv
design/wavenet_top.sv
sim/tb_wavenet.sv

// ==== sim/tb_ref_model.svh ====
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// ------------------------------------------------------------
// golden model of the three layer network
// ------------------------------------------------------------

// deep enough for the widest cache, newest entry at index 0
localparam int hist_depth = (num_taps - 1) * cache_dilation[num_layers-2] + 1;
localparam longint sat_max = (longint'(1) <<< (act_width - 1)) - 1;
localparam longint sat_min = -(longint'(1) <<< (act_width - 1));

act_t      in_hist [hist_depth];
chan_vec_t l0_hist [hist_depth];
chan_vec_t l1_hist [hist_depth];

// one layer over a full window, all output channels
function automatic chan_vec_t layer_response(input int lyr, input window_t win);
    chan_vec_t res;
    longint    sum;
    res = '0;
    for (int o = 0; o < num_ch; o++) begin
        sum = 0;
        for (int k = 0; k < num_taps; k++) begin
            for (int c = 0; c < layer_in_ch[lyr]; c++) begin
                sum += longint'(layer_weight[lyr][o][k][c]) * longint'(win[k][c]);
            end
        end
        sum = (sum + longint'(layer_bias[lyr][o]) * (longint'(1) <<< frac_bits)) >>> frac_bits;
        if (sum > sat_max) begin
            sum = sat_max;
        end else if (sum < sat_min) begin
            sum = sat_min;
        end
        // hidden layers clamp negatives
        if (lyr < num_layers - 1 && sum < 0) begin
            sum = 0;
        end
        res[o] = act_t'(sum);
    end
    return res;
endfunction

task automatic clear_history();
    for (int i = 0; i < hist_depth; i++) begin
        in_hist[i] = '0;
        l0_hist[i] = '0;
        l1_hist[i] = '0;
    end
endtask

// advance all histories by one sample and predict layer 2
task automatic next_expected(input act_t s, output chan_vec_t expected);
    window_t   w;
    chan_vec_t l0;
    chan_vec_t l1;
    for (int i = hist_depth - 1; i > 0; i--) begin
        in_hist[i] = in_hist[i-1];
        l0_hist[i] = l0_hist[i-1];
        l1_hist[i] = l1_hist[i-1];
    end
    in_hist[0] = s;
    w = '0;
    for (int k = 0; k < num_taps; k++) begin
        w[k][0] = in_hist[num_taps-1-k];
    end
    l0 = layer_response(0, w);
    l0_hist[0] = l0;
    for (int k = 0; k < num_taps; k++) begin
        w[k] = l0_hist[(num_taps-1-k) * cache_dilation[0]];
    end
    l1 = layer_response(1, w);
    l1_hist[0] = l1;
    for (int k = 0; k < num_taps; k++) begin
        w[k] = l1_hist[(num_taps-1-k) * cache_dilation[1]];
    end
    expected = layer_response(2, w);
endtask

`endif

// ==== sim/tb_wavenet.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_wavenet;
    import wavenet_pkg::*;

    localparam int n_impulse   = 70;
    localparam int n_random    = 120;
    localparam int n_busy      = 20;
    localparam int n_extra     = 3;
    localparam int n_pre_rst   = 4;
    localparam int n_post_rst  = 30;
    localparam int n_offered   = n_impulse + n_random + n_busy * (1 + n_extra)
                               + n_pre_rst + 1 + n_post_rst;
    localparam int cycle_limit = 60 * n_offered + 200;

    logic        clk;
    logic        rst;
    act_t        sample;
    logic        sample_v;
    logic        busy;
    chan_vec_t   result;
    logic        result_v;

    int          errors;
    int          proto_errors;
    int          checks;
    int          cycles;
    int          pulse_total;
    int          sample_idx;
    int          errors_at_start;
    logic [31:0] rng;
    string       test_name;

    `include "tb_ref_model.svh"

    wavenet_top i_dut (
        .clk      (clk),
        .rst      (rst),
        .sample   (sample),
        .sample_v (sample_v),
        .busy     (busy),
        .result   (result),
        .result_v (result_v)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    // ------------------------------------------------------------
    // protocol checks on every edge
    // ------------------------------------------------------------
    busy_rises: assert property (@(posedge clk) disable iff (rst)
        (!busy && sample_v) |=> busy)
    else begin
        errors++;
        proto_errors++;
        $display("%s: busy did not rise after an accepted strobe", test_name);
    end

    idle_at_pulse: assert property (@(posedge clk) disable iff (rst)
        result_v |-> !busy)
    else begin
        errors++;
        proto_errors++;
        $display("%s: busy was still high during the result_v pulse", test_name);
    end

    pulse_at_fall: assert property (@(posedge clk) disable iff (rst)
        $fell(busy) |-> result_v)
    else begin
        errors++;
        proto_errors++;
        $display("%s: busy fell without a result_v pulse", test_name);
    end

    pulse_width: assert property (@(posedge clk) disable iff (rst)
        result_v |=> !result_v)
    else begin
        errors++;
        proto_errors++;
        $display("%s: result_v stayed high for more than one cycle", test_name);
    end

    result_held: assert property (@(posedge clk) disable iff (rst)
        !busy |-> $stable(result))
    else begin
        errors++;
        proto_errors++;
        $display("%s: result changed while the DUT was idle", test_name);
    end

    // ------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] v);
        logic [31:0] x;
        x = v;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // uniform in -4.0 .. +4.0
    task automatic draw_sample(output act_t s);
        rng = xorshift32(rng);
        s = act_t'(int'(rng % 32'd2049) - 1024);
    endtask

    task automatic start_test(input string name);
        test_name = name;
        sample_idx = 0;
        errors_at_start = errors;
    endtask

    task automatic end_test();
        $display("test %s: %0d samples, %0d errors", test_name, sample_idx,
                 errors - errors_at_start);
    endtask

    task automatic check_idle(input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            checks++;
            assert (busy === 1'b0 && result_v === 1'b0 && result === '0) else begin
                errors++;
                $display("mismatch %s: expected busy 0 result_v 0 result %h, actual %b %b %h",
                         test_name, chan_vec_t'('0), busy, result_v, result);
            end
        end
    endtask

    // one accepted sample, optional strobes while busy, then compare
    task automatic run_sample(input act_t s, input int extra);
        chan_vec_t expected;
        act_t      junk;
        int        pulses;
        int        cyc;
        int        left;
        @(posedge clk);
        sample   <= s;
        sample_v <= 1'b1;
        @(posedge clk);
        sample_v <= 1'b0;
        next_expected(s, expected);
        sample_idx++;
        pulses = 0;
        cyc = 0;
        left = extra;
        @(negedge clk);
        assert (busy === 1'b1) else begin
            errors++;
            $display("%s: busy did not rise for sample %0d", test_name, sample_idx);
        end
        while (busy === 1'b1) begin
            @(posedge clk);
            // early in the run, well before the last layer
            if (left > 0 && cyc % 5 == 1) begin
                draw_sample(junk);
                sample   <= junk;
                sample_v <= 1'b1;
                left--;
            end else begin
                sample_v <= 1'b0;
            end
            @(negedge clk);
            cyc++;
            if (result_v === 1'b1) begin
                pulses++;
            end
        end
        pulse_total += pulses;
        checks += 2;
        assert (pulses == 1) else begin
            errors++;
            $display("mismatch %s: sample %0d expected 1 result_v pulse, actual %0d",
                     test_name, sample_idx, pulses);
        end
        assert (result === expected) else begin
            errors++;
            $display("mismatch %s: sample %0d expected %h actual %h",
                     test_name, sample_idx, expected, result);
        end
        if (extra > 0) begin
            repeat (2) @(negedge clk);
            checks++;
            assert (busy === 1'b0) else begin
                errors++;
                $display("%s: a strobe given while busy started another run", test_name);
            end
        end
    endtask

    // ------------------------------------------------------------
    // watchdog
    // ------------------------------------------------------------
    initial begin
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the DUT did not finish within %0d cycles", cycle_limit);
        $display("Test failed");
        $finish;
    end

    // ------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------
    initial begin
        act_t s;
        rst = 1'b1;
        sample = '0;
        sample_v = 1'b0;
        errors = 0;
        proto_errors = 0;
        checks = 0;
        pulse_total = 0;
        rng = 32'hc617c446;
        test_name = "reset";
        clear_history();
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        start_test("after_reset");
        check_idle(8);
        end_test();

        start_test("impulse");
        run_sample(act_t'(256), 0);
        for (int i = 1; i < n_impulse; i++) begin
            run_sample('0, 0);
        end
        end_test();

        start_test("random_stream");
        for (int i = 0; i < n_random; i++) begin
            draw_sample(s);
            run_sample(s, 0);
        end
        end_test();

        start_test("strobe_while_busy");
        for (int i = 0; i < n_busy; i++) begin
            draw_sample(s);
            run_sample(s, n_extra);
        end
        end_test();

        start_test("reset_mid_run");
        for (int i = 0; i < n_pre_rst; i++) begin
            draw_sample(s);
            run_sample(s, 0);
        end
        draw_sample(s);
        @(posedge clk);
        sample   <= s;
        sample_v <= 1'b1;
        @(posedge clk);
        sample_v <= 1'b0;
        repeat (10) @(negedge clk);
        checks++;
        assert (busy === 1'b1) else begin
            errors++;
            $display("%s: the run was not in progress when reset was applied", test_name);
        end
        @(posedge clk);
        rst <= 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        clear_history();
        check_idle(4);
        for (int i = 0; i < n_post_rst; i++) begin
            draw_sample(s);
            run_sample(s, 0);
        end
        end_test();

        $display("test output_pulse: %0d pulses, %0d protocol errors", pulse_total,
                 proto_errors);
        $display("checks %0d, errors %0d, cycles %0d", checks, errors, cycles);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== design/wavenet_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module wavenet_top (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire wavenet_pkg::act_t sample,
    input  wire logic              sample_v,
    output logic                   busy,
    output wavenet_pkg::chan_vec_t result,
    output logic                   result_v
);
    import wavenet_pkg::*;

    logic                  in_shift;
    logic [num_layers-2:0] cache_shift;

    stage_if l0_if ();
    stage_if l1_if ();
    stage_if l2_if ();

    // ----------------------------------------------------------
    // data path
    // ----------------------------------------------------------
    input_window i_window (
        .clk    (clk),
        .rst    (rst),
        .shift  (in_shift),
        .sample (sample),
        .win    (l0_if)
    );

    conv_layer #(.layer(0)) i_conv0 (
        .clk (clk),
        .rst (rst),
        .st  (l0_if)
    );

    dilated_cache #(.dilation(cache_dilation[0])) i_cache0 (
        .clk   (clk),
        .rst   (rst),
        .shift (cache_shift[0]),
        .din   (l0_if.result),
        .win   (l1_if)
    );

    conv_layer #(.layer(1)) i_conv1 (
        .clk (clk),
        .rst (rst),
        .st  (l1_if)
    );

    dilated_cache #(.dilation(cache_dilation[1])) i_cache1 (
        .clk   (clk),
        .rst   (rst),
        .shift (cache_shift[1]),
        .din   (l1_if.result),
        .win   (l2_if)
    );

    conv_layer #(.layer(2)) i_conv2 (
        .clk (clk),
        .rst (rst),
        .st  (l2_if)
    );

    // ----------------------------------------------------------
    // control
    // ----------------------------------------------------------
    layer_sequencer i_seq (
        .clk         (clk),
        .rst         (rst),
        .sample_v    (sample_v),
        .busy        (busy),
        .in_shift    (in_shift),
        .cache_shift (cache_shift),
        .st0         (l0_if),
        .st1         (l1_if),
        .st2         (l2_if),
        .result_v    (result_v)
    );

    // last layer holds its result until the next run completes
    assign result = l2_if.result;

endmodule

`default_nettype wire

// ==== design/layer_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module layer_sequencer (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic                          sample_v,
    output logic                               busy,
    output logic                               in_shift,
    output logic [wavenet_pkg::num_layers-2:0] cache_shift,
    stage_if.ctrl                              st0,
    stage_if.ctrl                              st1,
    stage_if.ctrl                              st2,
    output logic                               result_v
);
    import wavenet_pkg::*;

    localparam int               idx_w      = $clog2(num_layers);
    localparam logic [idx_w-1:0] last_layer = idx_w'(num_layers - 1);

    seq_state_t            state;
    logic [idx_w-1:0]      lidx;
    logic [num_layers-1:0] done_vec;
    logic [num_layers-1:0] start_vec;

    // ----------------------------------------------------------
    // strobes decoded from state and layer index
    // ----------------------------------------------------------
    assign busy     = (state != idle);
    assign in_shift = (state == idle) && sample_v;
    assign done_vec = {st2.done, st1.done, st0.done};

    always_comb begin
        for (int k = 0; k < num_layers; k++) begin
            start_vec[k] = (state == start_layer) && (lidx == idx_w'(k));
        end
        // cache k sits behind layer k
        for (int k = 0; k < num_layers - 1; k++) begin
            cache_shift[k] = (state == capture) && (lidx == idx_w'(k));
        end
    end

    assign st0.start = start_vec[0];
    assign st1.start = start_vec[1];
    assign st2.start = start_vec[2];

    // ----------------------------------------------------------
    // FSM, one pass through all layers per accepted sample
    // ----------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= idle;
            lidx     <= '0;
            result_v <= 1'b0;
        end else begin
            result_v <= 1'b0;
            case (state)
                idle: begin
                    if (sample_v) begin
                        state <= shift_in;
                    end
                end
                shift_in: begin
                    lidx  <= '0;
                    state <= start_layer;
                end
                start_layer: begin
                    state <= wait_layer;
                end
                wait_layer: begin
                    if (done_vec[lidx]) begin
                        if (lidx == last_layer) begin
                            state <= emit;
                        end else begin
                            state <= capture;
                        end
                    end
                end
                capture: begin
                    lidx  <= lidx + 1'b1;
                    state <= start_layer;
                end
                emit: begin
                    // busy drops on the same edge
                    result_v <= 1'b1;
                    state    <= idle;
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/conv_layer.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_layer #(
    parameter int layer = 0
) (
    input wire logic clk,
    input wire logic rst,
    stage_if.engine  st
);
    import wavenet_pkg::*;

    localparam int   in_ch    = layer_in_ch[layer];
    localparam int   steps    = in_ch * num_taps;
    localparam int   step_w   = $clog2(steps + 1);
    localparam bit   use_relu = (layer < num_layers - 1);
    localparam acc_t sat_hi   = acc_t'((2 ** (act_width - 1)) - 1);
    localparam acc_t sat_lo   = -acc_t'(2 ** (act_width - 1));

    logic              running;
    logic              last;
    logic              mac_en;
    logic [step_w-1:0] step;
    logic [step_w-1:0] mac_step;
    int                tap_sel;
    int                ch_sel;
    act_t              x;
    acc_t              prod [num_ch];
    acc_t              acc [num_ch];

    // bias, back to Q8.8, clamp to 16 bits, then relu on hidden layers
    function automatic act_t finish(acc_t sum, act_t bias);
        acc_t total;
        act_t res;
        total = (sum + (acc_t'(bias) <<< frac_bits)) >>> frac_bits;
        if (total > sat_hi) begin
            res = act_t'(sat_hi);
        end else if (total < sat_lo) begin
            res = act_t'(sat_lo);
        end else begin
            res = act_t'(total);
        end
        if (use_relu && res < 0) begin
            res = '0;
        end
        return res;
    endfunction

    // ----------------------------------------------------------
    // step select, input channel runs fastest
    // ----------------------------------------------------------
    assign mac_step = st.start ? '0 : step;
    assign last     = (step == step_w'(steps));
    assign mac_en   = st.start || (running && !last);

    always_comb begin
        tap_sel = int'(mac_step) / in_ch;
        ch_sel  = int'(mac_step) % in_ch;
        x       = st.window[tap_sel][ch_sel];
        for (int o = 0; o < num_ch; o++) begin
            prod[o] = acc_t'(layer_weight[layer][o][tap_sel][ch_sel]) * acc_t'(x);
        end
    end

    // ----------------------------------------------------------
    // step counter, result and done
    // ----------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            running   <= 1'b0;
            step      <= '0;
            st.done   <= 1'b0;
            st.result <= '0;
        end else begin
            st.done <= 1'b0;
            if (st.start) begin
                running <= 1'b1;
                step    <= step_w'(1);
            end else if (running) begin
                if (last) begin
                    running <= 1'b0;
                    st.done <= 1'b1;
                    for (int o = 0; o < num_ch; o++) begin
                        st.result[o] <= finish(acc[o], layer_bias[layer][o]);
                    end
                end else begin
                    step <= step + 1'b1;
                end
            end
        end
    end

    // all output channels accumulate in parallel
    always_ff @(posedge clk) begin
        if (mac_en) begin
            for (int o = 0; o < num_ch; o++) begin
                // first product of a run replaces the previous sum
                acc[o] <= st.start ? prod[o] : acc[o] + prod[o];
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/dilated_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

module dilated_cache #(
    parameter int dilation = 4
) (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   shift,
    input  wire wavenet_pkg::chan_vec_t din,
    stage_if.source                     win
);
    import wavenet_pkg::*;

    // enough history to reach the oldest tap
    localparam int depth = (num_taps - 1) * dilation + 1;

    chan_vec_t line [depth];

    // ----------------------------------------------------------
    // delay line, entry 0 holds the latest capture
    // ----------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < depth; i++) begin
                line[i] <= '0;
            end
        end else if (shift) begin
            line[0] <= din;
            for (int i = 1; i < depth; i++) begin
                line[i] <= line[i-1];
            end
        end
    end

    // ----------------------------------------------------------
    // taps spaced by the dilation
    // ----------------------------------------------------------
    always_comb begin
        for (int k = 0; k < num_taps; k++) begin
            // tap k lags the newest entry by (3 - k) dilations
            win.window[k] = line[(num_taps - 1 - k) * dilation];
        end
    end

endmodule

`default_nettype wire

// ==== design/input_window.sv ====
`timescale 1ns/1ps
`default_nettype none

module input_window (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              shift,
    input  wire wavenet_pkg::act_t sample,
    stage_if.source                win
);
    import wavenet_pkg::*;

    act_t taps [num_taps];

    // left shift, newest sample lands in the top tap
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int k = 0; k < num_taps; k++) begin
                taps[k] <= '0;
            end
        end else if (shift) begin
            for (int k = 0; k < num_taps - 1; k++) begin
                taps[k] <= taps[k+1];
            end
            taps[num_taps-1] <= sample;
        end
    end

    // raw samples sit in channel 0, the rest stay zero
    always_comb begin
        win.window = '0;
        for (int k = 0; k < num_taps; k++) begin
            win.window[k][0] = taps[k];
        end
    end

endmodule

`default_nettype wire

// ==== design/stage_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// one layer's input window, handshake and held result
interface stage_if;
    import wavenet_pkg::*;

    window_t   window;
    logic      start;
    logic      done;
    chan_vec_t result;

    modport source (
        output window
    );

    modport ctrl (
        output start,
        input  done
    );

    modport engine (
        input  window,
        input  start,
        output result,
        output done
    );

endinterface

`default_nettype wire

// ==== design/wavenet_pkg.sv ====
`default_nettype none

package wavenet_pkg;

    // ----------------------------------------------------------
    // sizes and fixed point format (Q8.8)
    // ----------------------------------------------------------
    localparam int act_width  = 16;
    localparam int frac_bits  = 8;
    localparam int acc_width  = 40;
    localparam int num_taps   = 4;
    localparam int num_ch     = 4;
    localparam int num_layers = 3;

    typedef logic signed [act_width-1:0] act_t;
    typedef logic signed [acc_width-1:0] acc_t;

    // tap 3 is the newest sample, tap 0 the oldest
    typedef act_t [num_ch-1:0]        chan_vec_t;
    typedef chan_vec_t [num_taps-1:0] window_t;

    localparam int layer_in_ch [num_layers]      = '{1, 4, 4};
    localparam int cache_dilation [num_layers-1] = '{4, 16};

    // ----------------------------------------------------------
    // weights, [layer][out ch][tap][in ch], 256 = 1.0
    // ----------------------------------------------------------
    localparam act_t layer_weight [num_layers][num_ch][num_taps][num_ch] = '{
        // layer 0 has a single input channel
        '{
            '{'{  48, 0, 0, 0}, '{ -32, 0, 0, 0}, '{  96, 0, 0, 0}, '{ 160, 0, 0, 0}},
            '{'{ -64, 0, 0, 0}, '{  80, 0, 0, 0}, '{ -40, 0, 0, 0}, '{-120, 0, 0, 0}},
            '{'{  24, 0, 0, 0}, '{  56, 0, 0, 0}, '{ 128, 0, 0, 0}, '{ -72, 0, 0, 0}},
            '{'{ 200, 0, 0, 0}, '{ -16, 0, 0, 0}, '{  32, 0, 0, 0}, '{  88, 0, 0, 0}}
        },
        '{
            '{'{  40,  -96,   64,   20}, '{ -24,  112,    8,  -56},
              '{  72,   16,  -88,   36}, '{ 128,  -48,   60,   96}},
            '{'{ -80,   28,   44,  120}, '{  52,  -36,  100,   12},
              '{ -16,   84,  -60,  140}, '{  92,   64,  -28, -104}},
            '{'{  36,   76,  -20,  -44}, '{ 104,  -68,   56,   24},
              '{  60,   32,  148,  -84}, '{-112,   88,   40,  156}},
            '{'{ -52,   44,  116,   68}, '{  20,  132,  -76,   48},
              '{  88,  -40,   24,  180}, '{ 140,  -64,   96,  -32}}
        },
        // output layer, no relu
        '{
            '{'{  96, -140,   60,   36}, '{ -72,  180,  -44,   88},
              '{ 120,   52, -160,   24}, '{-200,   84,  140,  -56}},
            '{'{-120,   64,  200,  -88}, '{  48, -152,   76,  112},
              '{ -36,   96, -124,  164}, '{ 172,  -60,   44, -188}},
            '{'{  80,  116,  -96,   52}, '{-164,   40,  136,  -72},
              '{ 104, -180,   68,   92}, '{  56,  148, -112,   20}},
            '{'{ -44,  -88,  152,  124}, '{ 132,   28, -196,   60},
              '{ -92,  168,   36, -140}, '{  76, -104,  184,   44}}
        }
    };

    localparam act_t layer_bias [num_layers][num_ch] = '{
        '{ 32, -64,  16,  -8},
        '{-24,  40, -96,  12},
        '{ 64, -32, 100, -16}
    };

    typedef enum logic [2:0] {
        idle,
        shift_in,
        start_layer,
        wait_layer,
        capture,
        emit
    } seq_state_t;

endpackage

`default_nettype wire
